// File: files.f
verilog/screenPkg.sv
verilog/colorPkg.sv
verilog/memPort.sv
verilog/viewScroller.sv
verilog/mapFetcher.sv
verilog/mapArbiter.sv
verilog/mapMemory.sv
verilog/pixelComposer.sv
verilog/gameDisplay.sv
sim/clockGen.sv
sim/gameDisplayTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module gameDisplayTb \
    -Mdir obj_dir -o gameDisplaySim \
    -f files.f

status=0
./obj_dir/gameDisplaySim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: sim/clockGen.sv
`default_nettype none

module clockGen (
    output logic frame_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    localparam int HalfPeriod = 10;

    // free running, starts low
    initial begin
        frame_clk = 1'b0;
        forever #(HalfPeriod) frame_clk = ~frame_clk;
    end

endmodule

`default_nettype wire

// File: sim/gameDisplayTb.sv
`default_nettype none

module gameDisplayTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ClockPeriod = 20;
    localparam int Writes = 48;
    // window size in map pixels
    localparam int ViewW = screenPkg::WinWidth / screenPkg::PixScale;
    localparam int ViewH = screenPkg::WinHeight / screenPkg::PixScale;

    // rough test lengths in cycles, for the watchdog
    localparam int HandshakeLen = Writes * 10;
    // one checkView covers its random pixels plus every written address
    localparam int ViewLen = 128;
    localparam int BackPressureLen = 40 * (Writes + 2) + 16;
    localparam int ScrollLen = 200 * 2 + 6 * ViewLen;
    localparam int TotalCycles = 8 + HandshakeLen + BackPressureLen + ViewLen + 400 + 160
        + ScrollLen + 18;

    logic frame_clk;
    logic Reset;
    logic frameStart;
    logic [7:0] keycode;
    logic [screenPkg::CoordW-1:0] DrawX;
    logic [screenPkg::CoordW-1:0] DrawY;
    logic visible;
    logic [screenPkg::CoordW-1:0] ballX;
    logic [screenPkg::CoordW-1:0] ballY;
    logic [screenPkg::CoordW-1:0] ballSize;
    logic hostReq;
    logic [screenPkg::MapAddrW-1:0] hostAddr;
    logic [colorPkg::IndexW-1:0] hostData;
    logic hostAck;
    logic [7:0] Red;
    logic [7:0] Green;
    logic [7:0] Blue;

    // shadow map, written addresses, shadow scroll
    logic [colorPkg::IndexW-1:0] shadowMap [screenPkg::MapWidth * screenPkg::MapHeight];
    logic [screenPkg::MapAddrW-1:0] written [$];
    int scrollXModel;
    int scrollYModel;
    // expected {valid, r, g, b}, two stages
    logic [24:0] expOne;
    logic [24:0] expTwo;
    logic fetchWanted;
    int errors;
    int pixelsChecked;
    int testCount;
    int seed;

    clockGen clocks (.frame_clk(frame_clk));

    gameDisplay uut (
        .frame_clk(frame_clk), .Reset(Reset), .frameStart(frameStart), .keycode(keycode),
        .DrawX(DrawX), .DrawY(DrawY), .visible(visible),
        .ballX(ballX), .ballY(ballY), .ballSize(ballSize),
        .hostReq(hostReq), .hostAddr(hostAddr), .hostData(hostData), .hostAck(hostAck),
        .Red(Red), .Green(Green), .Blue(Blue)
    );

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic logic insideWindow(input int x, input int y);
        return x >= int'(screenPkg::WinLeft) && x < int'(screenPkg::WinLeft + screenPkg::WinWidth)
            && y >= int'(screenPkg::WinTop) && y < int'(screenPkg::WinTop + screenPkg::WinHeight);
    endfunction

    function automatic logic [23:0] expectedColour(input int x, input int y, input logic vis);
        int dx;
        int dy;
        int mapAddr;
        logic [11:0] entry;
        dx = x - int'(ballX);
        dy = y - int'(ballY);
        if (!vis)
            return 24'h0;
        // disc first, then window, else black
        if (dx * dx + dy * dy <= int'(ballSize) * int'(ballSize))
            return {colorPkg::BallRed, colorPkg::BallGreen, colorPkg::BallBlue};
        if (!insideWindow(x, y))
            return 24'h0;
        mapAddr = ((y - int'(screenPkg::WinTop)) / screenPkg::PixScale + scrollYModel)
            * screenPkg::MapWidth
            + (x - int'(screenPkg::WinLeft)) / screenPkg::PixScale + scrollXModel;
        entry = colorPkg::Palette[shadowMap[mapAddr]];
        return {entry[11:8], 4'h0, entry[7:4], 4'h0, entry[3:0], 4'h0};
    endfunction

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    assign fetchWanted = visible && insideWindow(int'(DrawX), int'(DrawY));

    // inputs are stable here, scroll moves after the pixel is taken
    always @(posedge frame_clk) begin
        if (Reset) begin
            expOne <= '0;
            expTwo <= '0;
            scrollXModel = 0;
            scrollYModel = 0;
        end else begin
            expOne <= {1'b1, expectedColour(int'(DrawX), int'(DrawY), visible)};
            expTwo <= expOne;
            pixelsChecked++;
            if (frameStart && keycode == screenPkg::KeyLeft && scrollXModel > 0)
                scrollXModel--;
            if (frameStart && keycode == screenPkg::KeyRight
                && scrollXModel < int'(screenPkg::ScrollXMax))
                scrollXModel++;
            if (frameStart && keycode == screenPkg::KeyUp && scrollYModel > 0)
                scrollYModel--;
            if (frameStart && keycode == screenPkg::KeyDown
                && scrollYModel < int'(screenPkg::ScrollYMax))
                scrollYModel++;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    ackNeedsReq: assert property (@(posedge frame_clk) disable iff (Reset)
        $rose(hostAck) |-> $past(hostReq))
        else begin
            errors++;
            $display("hostAck rose with no host request at %0t", $time);
        end

    ackHeld: assert property (@(posedge frame_clk) disable iff (Reset)
        hostAck && hostReq |=> hostAck)
        else begin
            errors++;
            $display("hostAck fell while hostReq was still high at %0t", $time);
        end

    ackReleased: assert property (@(posedge frame_clk) disable iff (Reset)
        hostAck && !hostReq |=> !hostAck)
        else begin
            errors++;
            $display("hostAck did not fall after hostReq dropped at %0t", $time);
        end

    // fetcher has priority over the host
    ackBlocked: assert property (@(posedge frame_clk) disable iff (Reset)
        !hostAck && fetchWanted |=> !hostAck)
        else begin
            errors++;
            $display("host write granted during an in-window pixel at %0t", $time);
        end

    ackGranted: assert property (@(posedge frame_clk) disable iff (Reset)
        hostReq && !hostAck && !fetchWanted |=> hostAck)
        else begin
            errors++;
            $display("host write not granted on an idle cycle at %0t", $time);
        end

    // outputs are registered, so the falling edge sees settled values
    resetState: assert property (@(negedge frame_clk)
        Reset |-> hostAck == 1'b0 && {Red, Green, Blue} == 24'h0)
        else begin
            errors++;
            $display("ERR reset state hostAck %h Red %h Green %h Blue %h",
                hostAck, Red, Green, Blue);
        end

    rgbMatch: assert property (@(negedge frame_clk) disable iff (Reset)
        expTwo[24] |-> {Red, Green, Blue} == expTwo[23:0])
        else begin
            errors++;
            if (Red != expTwo[23:16])
                $display("ERR Red expected %h got %h at %0t", expTwo[23:16], Red, $time);
            if (Green != expTwo[15:8])
                $display("ERR Green expected %h got %h at %0t", expTwo[15:8], Green, $time);
            if (Blue != expTwo[7:0])
                $display("ERR Blue expected %h got %h at %0t", expTwo[7:0], Blue, $time);
        end

    // ------------------------------------------------------------------------
    // stimulus tasks, all start and end on a falling edge
    // ------------------------------------------------------------------------

    task automatic drivePixel(input int x, input int y, input logic vis);
        DrawX = screenPkg::CoordW'(x);
        DrawY = screenPkg::CoordW'(y);
        visible = vis;
        @(negedge frame_clk);
    endtask

    task automatic driveOutside(input logic vis);
        int x;
        int y;
        do begin
            x = randBelow(640);
            y = randBelow(480);
        end while (insideWindow(x, y));
        drivePixel(x, y, vis);
    endtask

    task automatic hostWrite(input int addr, input int data);
        int extra;
        extra = randBelow(3);
        hostAddr = screenPkg::MapAddrW'(addr);
        hostData = colorPkg::IndexW'(data);
        hostReq = 1'b1;
        @(negedge frame_clk);
        while (!hostAck)
            @(negedge frame_clk);
        shadowMap[addr] = colorPkg::IndexW'(data);
        written.push_back(screenPkg::MapAddrW'(addr));
        // req held a little past the ack
        repeat (extra) @(negedge frame_clk);
        hostReq = 1'b0;
        @(negedge frame_clk);
        while (hostAck)
            @(negedge frame_clk);
    endtask

    // random window pixels, then every written address now in view
    task automatic checkView(input int count);
        int mx;
        int my;
        repeat (count) begin
            drivePixel(int'(screenPkg::WinLeft) + randBelow(int'(screenPkg::WinWidth)),
                int'(screenPkg::WinTop) + randBelow(int'(screenPkg::WinHeight)), 1'b1);
        end
        foreach (written[i]) begin
            mx = int'(written[i]) % screenPkg::MapWidth;
            my = int'(written[i]) / screenPkg::MapWidth;
            if (mx >= scrollXModel && mx < scrollXModel + ViewW
                && my >= scrollYModel && my < scrollYModel + ViewH) begin
                drivePixel(int'(screenPkg::WinLeft)
                    + screenPkg::PixScale * (mx - scrollXModel) + randBelow(2),
                    int'(screenPkg::WinTop)
                    + screenPkg::PixScale * (my - scrollYModel) + randBelow(2), 1'b1);
            end
        end
    endtask

    task automatic sweepBall();
        for (int dy = -12; dy <= 12; dy += 2)
            for (int dx = -12; dx <= 12; dx += 2)
                drivePixel(int'(ballX) + dx, int'(ballY) + dy, 1'b1);
    endtask

    task automatic pulseKey(input logic [7:0] key, input int count);
        visible = 1'b0;
        repeat (count) begin
            keycode = key;
            frameStart = 1'b1;
            @(negedge frame_clk);
            frameStart = 1'b0;
            @(negedge frame_clk);
        end
    endtask

    // flush the two pipeline stages, then report
    task automatic reportTest(input string name, input int start);
        repeat (3) drivePixel(0, 0, 1'b0);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errors - start);
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        int start;
        seed = 32'hecfd7ab5;
        errors = 0;
        pixelsChecked = 0;
        testCount = 0;
        Reset = 1'b1;
        frameStart = 1'b0;
        keycode = 8'h00;
        DrawX = '0;
        DrawY = '0;
        visible = 1'b0;
        // ball parked in a corner away from the window
        ballX = 10'd620;
        ballY = 10'd470;
        ballSize = 10'd3;
        hostReq = 1'b0;
        hostAddr = '0;
        hostData = '0;
        foreach (shadowMap[i])
            shadowMap[i] = '0;
        repeat (4) @(negedge frame_clk);
        Reset = 1'b0;

        start = errors;
        repeat (Writes) hostWrite(randBelow(32768), randBelow(16));
        reportTest("host handshake", start);

        // host waits out a run of in-window pixels
        start = errors;
        hostAddr = screenPkg::MapAddrW'(randBelow(32768));
        hostData = colorPkg::IndexW'(randBelow(16));
        hostReq = 1'b1;
        repeat (40) checkView(1);
        while (!hostAck)
            driveOutside(1'b1);
        shadowMap[hostAddr] = hostData;
        written.push_back(hostAddr);
        hostReq = 1'b0;
        driveOutside(1'b1);
        while (hostAck)
            driveOutside(1'b1);
        reportTest("host back-pressure", start);

        start = errors;
        checkView(48);
        reportTest("background colour", start);

        start = errors;
        ballX = 10'd200;
        ballY = 10'd150;
        ballSize = 10'd10;
        sweepBall();
        // disc outside the window, black around it
        ballX = 10'd40;
        ballY = 10'd40;
        ballSize = 10'd8;
        sweepBall();
        reportTest("sprite", start);

        start = errors;
        repeat (64) driveOutside(1'b1);
        ballX = 10'd200;
        ballY = 10'd150;
        drivePixel(200, 150, 1'b0);
        repeat (64) drivePixel(randBelow(640), randBelow(480), 1'b0);
        ballX = 10'd620;
        ballY = 10'd470;
        ballSize = 10'd3;
        reportTest("black outside", start);

        // clamp at zero, run to both maxima, unknown key, back off
        start = errors;
        pulseKey(screenPkg::KeyLeft, 3);
        pulseKey(screenPkg::KeyUp, 3);
        checkView(24);
        pulseKey(screenPkg::KeyRight, 130);
        checkView(24);
        pulseKey(screenPkg::KeyDown, 34);
        checkView(24);
        pulseKey(8'h2C, 3);
        checkView(24);
        pulseKey(screenPkg::KeyLeft, 5);
        pulseKey(screenPkg::KeyUp, 4);
        checkView(24);
        pulseKey(screenPkg::KeyRight, 2);
        checkView(24);
        reportTest("scrolling", start);

        $display("tests %0d, pixels checked %0d, errors %0d", testCount, pixelsChecked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // twice the summed test lengths
    initial begin
        #(TotalCycles * 2 * ClockPeriod);
        $display("timeout, tests did not finish in %0d cycles", TotalCycles * 2);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/colorPkg.sv
`default_nettype none

package colorPkg;

    // background index width
    localparam int IndexW = 4;

    // -------------------------------------------------------------------------
    // palette, 12 bit rgb with 4 bits per channel
    // -------------------------------------------------------------------------

    // entry 0 first
    localparam logic [0:15][11:0] Palette = '{
        12'h000,
        // grass shades
        12'h0A4,
        12'h3C5,
        12'h8D6,
        // water
        12'h26B,
        12'h48E,
        12'h9CF,
        // dirt and path
        12'hA73,
        12'hC95,
        12'hEDB,
        // stone greys
        12'h777,
        12'hAAA,
        12'hFFF,
        // trees and roofs
        12'h930,
        12'h5A2,
        12'hD33
    };

    // player sprite colour, full 8 bit channels
    localparam logic [7:0] BallRed = 8'hFF;
    localparam logic [7:0] BallGreen = 8'h55;
    localparam logic [7:0] BallBlue = 8'h00;

endpackage

`default_nettype wire

// File: verilog/gameDisplay.sv
`default_nettype none

module gameDisplay (
    input wire frame_clk,
    input wire Reset,
    input wire frameStart,
    input wire [7:0] keycode,
    input wire [screenPkg::CoordW-1:0] DrawX,
    input wire [screenPkg::CoordW-1:0] DrawY,
    input wire visible,
    input wire [screenPkg::CoordW-1:0] ballX,
    input wire [screenPkg::CoordW-1:0] ballY,
    input wire [screenPkg::CoordW-1:0] ballSize,
    input wire hostReq,
    input wire [screenPkg::MapAddrW-1:0] hostAddr,
    input wire [colorPkg::IndexW-1:0] hostData,
    output logic hostAck,
    output logic [7:0] Red,
    output logic [7:0] Green,
    output logic [7:0] Blue
);

    // current view offset
    logic [screenPkg::ScrollXW-1:0] scrollX;
    logic [screenPkg::ScrollYW-1:0] scrollY;

    // arbiter to memory
    logic [screenPkg::MapAddrW-1:0] memAddr;
    logic [colorPkg::IndexW-1:0] memWdata;
    logic memWe;
    logic [colorPkg::IndexW-1:0] memRdata;

    memPort fetchPort ();

    // -------------------------------------------------------------------------
    // scroll, fetch, arbitration, storage, colour
    // -------------------------------------------------------------------------

    viewScroller scroller (
        .frame_clk(frame_clk),
        .Reset(Reset),
        .frameStart(frameStart),
        .keycode(keycode),
        .scrollX(scrollX),
        .scrollY(scrollY)
    );

    mapFetcher fetcher (
        .DrawX(DrawX),
        .DrawY(DrawY),
        .visible(visible),
        .scrollX(scrollX),
        .scrollY(scrollY),
        .mem(fetchPort.requester)
    );

    mapArbiter arbiter (
        .frame_clk(frame_clk),
        .Reset(Reset),
        .fetch(fetchPort.arbiter),
        .hostReq(hostReq),
        .hostAddr(hostAddr),
        .hostData(hostData),
        .hostAck(hostAck),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memWe(memWe),
        .memRdata(memRdata)
    );

    mapMemory memory (
        .frame_clk(frame_clk),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memWe(memWe),
        .memRdata(memRdata)
    );

    // index comes straight from the fetch port
    pixelComposer composer (
        .frame_clk(frame_clk),
        .Reset(Reset),
        .DrawX(DrawX),
        .DrawY(DrawY),
        .visible(visible),
        .ballX(ballX),
        .ballY(ballY),
        .ballSize(ballSize),
        .mapIndex(fetchPort.rdata),
        .Red(Red),
        .Green(Green),
        .Blue(Blue)
    );

endmodule

`default_nettype wire

// File: verilog/mapArbiter.sv
`default_nettype none

module mapArbiter (
    input wire frame_clk,
    input wire Reset,
    memPort.arbiter fetch,
    input wire hostReq,
    input wire [screenPkg::MapAddrW-1:0] hostAddr,
    input wire [colorPkg::IndexW-1:0] hostData,
    output logic hostAck,
    output logic [screenPkg::MapAddrW-1:0] memAddr,
    output logic [colorPkg::IndexW-1:0] memWdata,
    output logic memWe,
    input wire [colorPkg::IndexW-1:0] memRdata
);

    // host wants a write and has not been served yet
    logic hostPending;

    assign hostPending = hostReq && !hostAck;

    // -------------------------------------------------------------------------
    // memory select, fetcher always wins
    // -------------------------------------------------------------------------

    always_comb begin
        if (fetch.req) begin
            memAddr = fetch.addr;
            memWdata = fetch.wdata;
            memWe = fetch.we;
        end else begin
            memAddr = hostAddr;
            memWdata = hostData;
            // host write goes in on an idle cycle
            memWe = hostPending;
        end
    end

    // granted the same cycle, data one edge later
    assign fetch.ack = fetch.req;
    assign fetch.rdata = memRdata;

    // -------------------------------------------------------------------------
    // four phase host handshake
    // -------------------------------------------------------------------------

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            hostAck <= 1'b0;
        end else if (hostPending && !fetch.req) begin
            // write done this edge
            hostAck <= 1'b1;
        end else if (!hostReq) begin
            // host dropped req, return to idle
            hostAck <= 1'b0;
        end
    end

    // the fetcher port must stay read only
    noWriteOnFetch: assert property (
        @(posedge frame_clk) disable iff (Reset)
        !(memWe && fetch.req)
    );

    // ack only answers a live request
    ackNeedsReq: assert property (
        @(posedge frame_clk) disable iff (Reset)
        $rose(hostAck) |-> $past(hostReq)
    );

endmodule

`default_nettype wire

// File: verilog/mapFetcher.sv
`default_nettype none

module mapFetcher (
    input wire [screenPkg::CoordW-1:0] DrawX,
    input wire [screenPkg::CoordW-1:0] DrawY,
    input wire visible,
    input wire [screenPkg::ScrollXW-1:0] scrollX,
    input wire [screenPkg::ScrollYW-1:0] scrollY,
    memPort.requester mem
);

    // offset from the window corner in screen pixels
    logic [screenPkg::CoordW-1:0] offX;
    logic [screenPkg::CoordW-1:0] offY;

    // map pixel, one bit wider than needed
    logic [8:0] mapX;
    logic [7:0] mapY;
    logic [16:0] fullAddr;

    always_comb begin
        offX = DrawX - screenPkg::WinLeft;
        offY = DrawY - screenPkg::WinTop;

        // halve for double size, then shift by scroll
        mapX = 9'(offX / screenPkg::PixScale) + {1'b0, scrollX};
        mapY = 8'(offY / screenPkg::PixScale) + {2'b0, scrollY};

        // row major, MapWidth per row
        fullAddr = 17'(mapY) * 17'(screenPkg::MapWidth) + 17'(mapX);
    end

    // -------------------------------------------------------------------------
    // request drive
    // -------------------------------------------------------------------------

    // only in-window visible pixels need the map
    assign mem.req = visible && screenPkg::inWindow(DrawX, DrawY);
    assign mem.addr = fullAddr[screenPkg::MapAddrW-1:0];

    // read only port
    assign mem.we = 1'b0;
    assign mem.wdata = '0;

    // scroll plus offset has to stay on the map
    always_comb begin
        if (mem.req)
            addrOnMap: assert (fullAddr < 17'(screenPkg::MapWidth * screenPkg::MapHeight));
    end

endmodule

`default_nettype wire

// File: verilog/mapMemory.sv
`default_nettype none

module mapMemory (
    input wire frame_clk,
    input wire [screenPkg::MapAddrW-1:0] memAddr,
    input wire [colorPkg::IndexW-1:0] memWdata,
    input wire memWe,
    output logic [colorPkg::IndexW-1:0] memRdata
);

    localparam int Depth = screenPkg::MapWidth * screenPkg::MapHeight;

    // one palette index per map pixel
    logic [colorPkg::IndexW-1:0] store [Depth];

    // blank map at start
    initial begin
        for (int i = 0; i < Depth; i++)
            store[i] = '0;
    end

    // registered read, old data on a write cycle
    always_ff @(posedge frame_clk) begin
        if (memWe)
            store[memAddr] <= memWdata;
        memRdata <= store[memAddr];
    end

endmodule

`default_nettype wire

// File: verilog/memPort.sv
`default_nettype none

interface memPort;

    // request side
    logic req;
    logic [screenPkg::MapAddrW-1:0] addr;
    logic [colorPkg::IndexW-1:0] wdata;
    logic we;

    // arbiter side
    logic ack;
    logic [colorPkg::IndexW-1:0] rdata;

    modport requester (
        output req, addr, wdata, we,
        input ack, rdata
    );

    modport arbiter (
        input req, addr, wdata, we,
        output ack, rdata
    );

endinterface

`default_nettype wire

// File: verilog/pixelComposer.sv
`default_nettype none

module pixelComposer (
    input wire frame_clk,
    input wire Reset,
    input wire [screenPkg::CoordW-1:0] DrawX,
    input wire [screenPkg::CoordW-1:0] DrawY,
    input wire visible,
    input wire [screenPkg::CoordW-1:0] ballX,
    input wire [screenPkg::CoordW-1:0] ballY,
    input wire [screenPkg::CoordW-1:0] ballSize,
    input wire [colorPkg::IndexW-1:0] mapIndex,
    output logic [7:0] Red,
    output logic [7:0] Green,
    output logic [7:0] Blue
);

    localparam int SqW = 2 * screenPkg::CoordW + 2;

    // signed distance to ball centre
    logic signed [screenPkg::CoordW:0] distX;
    logic signed [screenPkg::CoordW:0] distY;
    logic [SqW-1:0] distSq;
    logic [SqW-1:0] sizeSq;

    // stage 1 flags, aligned with the memory read
    logic ballHit;
    logic winHit;
    logic visHit;

    // palette entry of the fetched index
    logic [11:0] entry;

    // -------------------------------------------------------------------------
    // stage 1, disc and window tests
    // -------------------------------------------------------------------------

    always_comb begin
        distX = $signed({1'b0, DrawX}) - $signed({1'b0, ballX});
        distY = $signed({1'b0, DrawY}) - $signed({1'b0, ballY});
        // circle test without a square root
        distSq = distX * distX + distY * distY;
        sizeSq = ballSize * ballSize;
    end

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            ballHit <= 1'b0;
            winHit <= 1'b0;
            visHit <= 1'b0;
        end else begin
            ballHit <= distSq <= sizeSq;
            winHit <= screenPkg::inWindow(DrawX, DrawY);
            visHit <= visible;
        end
    end

    // -------------------------------------------------------------------------
    // stage 2, colour select into the rgb register
    // -------------------------------------------------------------------------

    assign entry = colorPkg::Palette[mapIndex];

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            Red <= '0;
            Green <= '0;
            Blue <= '0;
        end else if (visHit && ballHit) begin
            // sprite sits over everything
            Red <= colorPkg::BallRed;
            Green <= colorPkg::BallGreen;
            Blue <= colorPkg::BallBlue;
        end else if (visHit && winHit) begin
            // 4 bit channels padded to 8
            Red <= {entry[11:8], 4'b0};
            Green <= {entry[7:4], 4'b0};
            Blue <= {entry[3:0], 4'b0};
        end else begin
            Red <= '0;
            Green <= '0;
            Blue <= '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/screenPkg.sv
`default_nettype none

package screenPkg;

    // -------------------------------------------------------------------------
    // screen side geometry
    // -------------------------------------------------------------------------

    // screen coordinate width
    localparam int CoordW = 10;

    // top left corner of the map window on screen
    localparam logic [CoordW-1:0] WinLeft = 10'd80;
    localparam logic [CoordW-1:0] WinTop = 10'd80;

    // window size in screen pixels
    localparam logic [CoordW-1:0] WinWidth = 10'd256;
    localparam logic [CoordW-1:0] WinHeight = 10'd192;

    // one map pixel spans a 2x2 block
    localparam int PixScale = 2;

    // -------------------------------------------------------------------------
    // map and scroll geometry
    // -------------------------------------------------------------------------

    localparam int MapWidth = 256;
    localparam int MapHeight = 128;
    localparam int MapAddrW = 15;

    // scroll range in map pixels
    localparam int ScrollXW = 8;
    localparam int ScrollYW = 6;
    localparam logic [ScrollXW-1:0] ScrollXMax = 8'd128;
    localparam logic [ScrollYW-1:0] ScrollYMax = 6'd32;

    // keyboard codes, wasd layout
    localparam logic [7:0] KeyLeft = 8'h04;
    localparam logic [7:0] KeyRight = 8'h07;
    localparam logic [7:0] KeyUp = 8'h1A;
    localparam logic [7:0] KeyDown = 8'h16;

    // inside test for the window region
    function automatic logic inWindow(input logic [CoordW-1:0] x, input logic [CoordW-1:0] y);
        inWindow = (x >= WinLeft) && (x < WinLeft + WinWidth) &&
                   (y >= WinTop) && (y < WinTop + WinHeight);
    endfunction

endpackage

`default_nettype wire

// File: verilog/viewScroller.sv
`default_nettype none

module viewScroller (
    input wire frame_clk,
    input wire Reset,
    input wire frameStart,
    input wire [7:0] keycode,
    output logic [screenPkg::ScrollXW-1:0] scrollX,
    output logic [screenPkg::ScrollYW-1:0] scrollY
);

    // -------------------------------------------------------------------------
    // one step per frame, held at the map edges
    // -------------------------------------------------------------------------

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            scrollX <= '0;
            scrollY <= '0;
        end else if (frameStart) begin
            case (keycode)
                screenPkg::KeyLeft: begin
                    // left edge of map
                    if (scrollX != '0)
                        scrollX <= scrollX - 1'b1;
                end
                screenPkg::KeyRight: begin
                    if (scrollX < screenPkg::ScrollXMax)
                        scrollX <= scrollX + 1'b1;
                end
                screenPkg::KeyUp: begin
                    // top edge
                    if (scrollY != '0)
                        scrollY <= scrollY - 1'b1;
                end
                screenPkg::KeyDown: begin
                    if (scrollY < screenPkg::ScrollYMax)
                        scrollY <= scrollY + 1'b1;
                end
                default: begin
                    // unknown key, view stays put
                    scrollX <= scrollX;
                    scrollY <= scrollY;
                end
            endcase
        end
    end

    // window must never leave the map
    scrollInRange: assert property (
        @(posedge frame_clk) disable iff (Reset)
        (scrollX <= screenPkg::ScrollXMax) && (scrollY <= screenPkg::ScrollYMax)
    );

endmodule

`default_nettype wire
